// File: jesd_loopback_sys.f
hw/jesd_tx_pkg.sv
hw/dac_pattern_gen.sv
hw/jesd_tx_framer.sv
hw/lane_scrambler.sv
hw/lane_descrambler.sv
hw/jesd_rx_deframer.sv
hw/jesd_loopback_sys.sv
verification/tb_clock_gen.sv
verification/jesd_loopback_tb.sv

// File: Makefile
# Verilator build and run for the JESD204B loopback testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := jesd_loopback_tb
FILELIST  := jesd_loopback_sys.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/jesd_loopback_tb.sv
// **********************************************************************
// Loopback testbench. Inputs change on the falling edge and outputs are
// sampled there too. Stimulus comes from a Galois LFSR with a fixed seed.
// Scrambling mode only changes once the pipeline has drained, since the
// scrambler and descrambler states must stay in step.
// **********************************************************************

`timescale 1ns/10ps

module jesd_loopback_tb;

  import jesd_tx_pkg::*;

  localparam int PLANNED_BEATS = 1600;
  localparam int CLOCK_NS = 20;
  localparam int TIMEOUT_NS = PLANNED_BEATS * CLOCK_NS * 4 + 4000;
  localparam int LANE_LATENCY = 3;
  localparam int RX_LATENCY = 5;
  localparam int TAIL_CYCLES = 8;

  logic            device_clk;
  logic            reset;
  logic            tx_enable;
  logic            scramble_enable;
  lane_beat_t      tx_lanes;
  logic            tx_lanes_valid;
  converter_beat_t rx_samples;
  logic            rx_valid;

  // Reset as the DUT saw it on the last rising edge
  logic reset_q = 1'b1;

  logic [31:0]                    lfsr_state = 32'h1eac_fc05;
  logic [PATTERN_COUNT_BITS-1:0]  model_count;
  logic [SCRAMBLE_STATE_BITS-1:0] model_hist [NUM_LANES];
  logic                           drain_pending;
  logic                           last_phase;

  // Expected beats in flight, with the cycle each one is due
  lane_beat_t      lane_q[$];
  int              lane_due_q[$];
  converter_beat_t rx_q[$];
  int              rx_due_q[$];
  logic            rx_phase_q[$];

  int cycle = 0;
  int sent_beats = 0;
  int checks = 0;
  int mismatches = 0;
  int faults = 0;
  int phase_changes = 0;
  int mode_changes = 0;
  int scrambled_beats = 0;
  int plain_beats = 0;

  tb_clock_gen u_tb_clock_gen (
    .device_clk (device_clk),
    .reset      (reset)
  );

  jesd_loopback_sys u_jesd_loopback_sys (
    .device_clk      (device_clk),
    .reset           (reset),
    .tx_enable       (tx_enable),
    .scramble_enable (scramble_enable),
    .tx_lanes        (tx_lanes),
    .tx_lanes_valid  (tx_lanes_valid),
    .rx_samples      (rx_samples),
    .rx_valid        (rx_valid)
  );

  always @(posedge device_clk) begin
    reset_q <= reset;
  end

  // **********************************************************************
  // Random source and reference models
  // **********************************************************************

  // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit handed out
  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int n = 0; n < count; n++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic sample_t pattern_sample(input int conv, input int pos,
                                             input logic [PATTERN_COUNT_BITS-1:0] count);
    logic [7:0] ramp;
    ramp = count[7:0] + 8'(pos);
    if (count[8]) begin
      return {4'(conv), 4'h0, ramp};
    end
    return {4'(conv), 4'(conv), 4'(conv), 4'(conv)};
  endfunction

  function automatic converter_beat_t expected_beat(input logic [PATTERN_COUNT_BITS-1:0] count);
    converter_beat_t beat;
    beat = '0;
    for (int i = 0; i < NUM_CONVERTERS; i++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        beat.samples[i][j] = pattern_sample(i, j, count);
      end
    end
    return beat;
  endfunction

  // Lane k holds converter k, each 16-bit sample byte swapped so its upper byte goes first
  function automatic lane_beat_t frame_beat(input converter_beat_t beat);
    lane_beat_t lanes;
    lanes = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        lanes[k][SAMPLE_BITS*j +: SAMPLE_BITS] =
          {beat.samples[k][j][7:0], beat.samples[k][j][15:8]};
      end
    end
    return lanes;
  endfunction

  // Serial 1 + x^14 + x^15 scrambler, octet 0 first and MSB first
  task automatic scramble_lane(input int k, input lane_word_t plain, output lane_word_t line);
    logic s;
    line = plain;
    for (int oct = 0; oct < LANE_BITS / 8; oct++) begin
      for (int b = 7; b >= 0; b--) begin
        s = plain[8*oct + b] ^ model_hist[k][SCRAMBLE_STATE_BITS-2]
            ^ model_hist[k][SCRAMBLE_STATE_BITS-1];
        line[8*oct + b] = s;
        model_hist[k] = {model_hist[k][SCRAMBLE_STATE_BITS-2:0], s};
      end
    end
  endtask

  // **********************************************************************
  // Output checks
  // **********************************************************************

  task automatic check_lanes();
    lane_beat_t expected;
    int due;
    if (!tx_lanes_valid) begin
      // A beat whose slot has passed without a strobe went missing
      if (lane_due_q.size() > 0) begin
        assert (lane_due_q[0] > cycle) else begin
          $display("lane beat due in cycle %0d never appeared on tx_lanes", lane_due_q[0]);
          faults++;
          void'(lane_q.pop_front());
          void'(lane_due_q.pop_front());
        end
      end
      return;
    end
    assert (lane_q.size() > 0) else begin
      $display("tx_lanes_valid high in cycle %0d with no beat in flight", cycle);
      faults++;
    end
    if (lane_q.size() == 0) begin
      return;
    end
    expected = lane_q.pop_front();
    due = lane_due_q.pop_front();
    checks += 2;
    assert (cycle == due) else begin
      $display("mismatch lane_latency: expected %0d actual %0d", due, cycle);
      mismatches++;
    end
    assert (tx_lanes === expected) else begin
      $display("mismatch %s: expected %h actual %h",
               scramble_enable ? "lane_scrambled" : "lane_plain", expected, tx_lanes);
      mismatches++;
    end
  endtask

  task automatic check_rx();
    converter_beat_t expected;
    int due;
    logic ramp;
    if (!rx_valid) begin
      if (rx_due_q.size() > 0) begin
        assert (rx_due_q[0] > cycle) else begin
          $display("rx beat due in cycle %0d never appeared on rx_samples", rx_due_q[0]);
          faults++;
          void'(rx_q.pop_front());
          void'(rx_due_q.pop_front());
          void'(rx_phase_q.pop_front());
        end
      end
      return;
    end
    assert (rx_q.size() > 0) else begin
      $display("rx_valid high in cycle %0d with no beat in flight", cycle);
      faults++;
    end
    if (rx_q.size() == 0) begin
      return;
    end
    expected = rx_q.pop_front();
    due = rx_due_q.pop_front();
    ramp = rx_phase_q.pop_front();
    checks++;
    assert (cycle == due) else begin
      $display("mismatch rx_latency: expected %0d actual %0d", due, cycle);
      mismatches++;
    end
    for (int k = 0; k < NUM_CONVERTERS; k++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        checks++;
        assert (rx_samples.samples[k][j] === expected.samples[k][j]) else begin
          $display("mismatch %s conv %0d sample %0d: expected %h actual %h",
                   ramp ? "ramp_phase" : "index_phase", k, j,
                   expected.samples[k][j], rx_samples.samples[k][j]);
          mismatches++;
        end
      end
    end
  endtask

  // **********************************************************************
  // Stimulus
  // **********************************************************************

  task automatic drive_inputs();
    logic [31:0] bits;
    converter_beat_t beat;
    lane_beat_t lanes;
    lane_word_t line;
    tx_enable = 1'b0;
    if (sent_beats >= PLANNED_BEATS) begin
      return;
    end
    if (!drain_pending) begin
      take_bits(7, bits);
      drain_pending = (bits[6:0] == 7'd0);
    end
    if (drain_pending) begin
      // Hold off new beats until the last one has left rx_samples
      if (rx_q.size() == 0) begin
        scramble_enable = ~scramble_enable;
        drain_pending = 1'b0;
        mode_changes++;
      end
      return;
    end
    take_bits(2, bits);
    if (bits[1:0] == 2'b00) begin
      return;
    end
    tx_enable = 1'b1;
    beat = expected_beat(model_count);
    lanes = frame_beat(beat);
    if (scramble_enable) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        scramble_lane(k, lanes[k], line);
        lanes[k] = line;
      end
      scrambled_beats++;
    end else begin
      plain_beats++;
    end
    lane_q.push_back(lanes);
    lane_due_q.push_back(cycle + LANE_LATENCY);
    rx_q.push_back(beat);
    rx_due_q.push_back(cycle + RX_LATENCY);
    rx_phase_q.push_back(model_count[8]);
    if (sent_beats > 0 && model_count[8] != last_phase) begin
      phase_changes++;
    end
    last_phase = model_count[8];
    // The model counter moves only on enabled beats, like the generator
    model_count += PATTERN_COUNT_BITS'(SAMPLES_PER_BEAT);
    sent_beats++;
  endtask

  initial begin
    int tail;
    tail = 0;
    tx_enable = 1'b0;
    scramble_enable = 1'b1;
    model_count = '0;
    drain_pending = 1'b0;
    last_phase = 1'b0;
    for (int k = 0; k < NUM_LANES; k++) begin
      model_hist[k] = '0;
    end
    while (tail < TAIL_CYCLES) begin
      @(negedge device_clk);
      cycle++;
      if (reset_q !== 1'b0) begin
        checks++;
        assert (tx_lanes_valid === 1'b0 && rx_valid === 1'b0) else begin
          $display("valid strobe high in cycle %0d while reset was active", cycle);
          faults++;
        end
        continue;
      end
      check_lanes();
      check_rx();
      drive_inputs();
      // A few idle cycles at the end catch any stray strobes
      if (sent_beats >= PLANNED_BEATS && rx_q.size() == 0) begin
        tail++;
      end
    end
    assert (phase_changes >= 4) else begin
      $display("pattern phase changed only %0d times", phase_changes);
      faults++;
    end
    assert (scrambled_beats > 0 && plain_beats > 0) else begin
      $display("run did not cover both scrambling modes");
      faults++;
    end
    $display("beats %0d, mode changes %0d, checks %0d, mismatches %0d, other errors %0d",
             sent_beats, mode_changes, checks, mismatches, faults);
    if (mismatches == 0 && faults == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Four clock periods per planned beat leaves room for gaps and drains
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run passed %0d ns with %0d of %0d beats sent",
             TIMEOUT_NS, sent_beats, PLANNED_BEATS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
// **********************************************************************
// Clock and reset source for the loopback testbench. device_clk has a
// 20 ns period. Reset is high for the first two rising edges and drops
// on the following falling edge.
// **********************************************************************

`timescale 1ns/10ps

module tb_clock_gen (
  output logic device_clk,
  output logic reset
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES = 2;

  initial begin
    device_clk = 1'b0;
    forever #(HALF_PERIOD_NS) device_clk = ~device_clk;
  end

  // Reset is released on a falling edge, like every other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge device_clk);
    @(negedge device_clk);
    reset = 1'b0;
  end

endmodule

// File: hw/jesd_loopback_sys.sv
// **********************************************************************
// Transmit path with a loopback receive path: pattern generator, framer,
// per-lane scramblers, per-lane descramblers and deframer. Each stage
// adds one cycle, so tx_lanes_valid trails an enabled edge by 3 cycles
// and rx_valid by 5. No link layer, SYSREF or serializer is present.
// **********************************************************************

`timescale 1ns/10ps

module jesd_loopback_sys (
  input  logic                         device_clk,
  input  logic                         reset,
  input  logic                         tx_enable,
  input  logic                         scramble_enable,
  output jesd_tx_pkg::lane_beat_t      tx_lanes,
  output logic                         tx_lanes_valid,
  output jesd_tx_pkg::converter_beat_t rx_samples,
  output logic                         rx_valid
);

  import jesd_tx_pkg::*;

  // Generator to framer
  converter_beat_t          gen_samples;
  logic                     gen_valid;

  // Framer to scramblers
  lane_beat_t               framed_lanes;
  logic                     framed_valid;

  // Per-lane strobes, all lanes move in lock step
  logic [NUM_LANES-1:0]     scram_valid;
  logic [NUM_LANES-1:0]     descram_valid;

  // Descramblers to deframer
  lane_beat_t               descram_lanes;

  // **********************************************************************
  // Transmit side
  // **********************************************************************

  dac_pattern_gen u_dac_pattern_gen (
    .device_clk (device_clk),
    .reset      (reset),
    .tx_enable  (tx_enable),
    .tx_samples (gen_samples),
    .tx_valid   (gen_valid)
  );

  jesd_tx_framer u_jesd_tx_framer (
    .device_clk    (device_clk),
    .reset         (reset),
    .frame_samples (gen_samples),
    .frame_valid   (gen_valid),
    .lane_data     (framed_lanes),
    .lane_valid    (framed_valid)
  );

  // **********************************************************************
  // Lanes, the scrambler outputs loop straight back to the receive side
  // **********************************************************************

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    lane_scrambler u_lane_scrambler (
      .device_clk      (device_clk),
      .reset           (reset),
      .scramble_enable (scramble_enable),
      .data_in         (framed_lanes[k]),
      .data_valid      (framed_valid),
      .data_out        (tx_lanes[k]),
      .out_valid       (scram_valid[k])
    );

    lane_descrambler u_lane_descrambler (
      .device_clk      (device_clk),
      .reset           (reset),
      .scramble_enable (scramble_enable),
      .data_in         (tx_lanes[k]),
      .data_valid      (scram_valid[k]),
      .data_out        (descram_lanes[k]),
      .out_valid       (descram_valid[k])
    );
  end

  // A beat counts once every lane has it
  assign tx_lanes_valid = &scram_valid;

  jesd_rx_deframer u_jesd_rx_deframer (
    .device_clk (device_clk),
    .reset      (reset),
    .lane_data  (descram_lanes),
    .lane_valid (&descram_valid),
    .rx_samples (rx_samples),
    .rx_valid   (rx_valid)
  );

endmodule

// File: hw/jesd_rx_deframer.sv
// **********************************************************************
// Loopback deframer, the registered inverse of jesd_tx_framer. Expects
// converter k on lane k with samples sent MSB octet first. All lanes
// must arrive on the same beat; there is no lane alignment.
// **********************************************************************

`timescale 1ns/10ps

module jesd_rx_deframer (
  input  logic                          device_clk,
  input  logic                          reset,
  input  jesd_tx_pkg::lane_beat_t       lane_data,
  input  logic                          lane_valid,
  output jesd_tx_pkg::converter_beat_t  rx_samples,
  output logic                          rx_valid
);

  import jesd_tx_pkg::*;

  // Samples before the output register
  converter_beat_t unpacked;

  // **********************************************************************
  // Octet to sample mapping
  // **********************************************************************

  always_comb begin
    unpacked = '0;
    for (int k = 0; k < NUM_CONVERTERS; k++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        for (int b = 0; b < OCTETS_PER_SAMPLE; b++) begin
          // The first octet of each sample rebuilds its upper byte
          unpacked.samples[k][j][SAMPLE_BITS - 1 - 8 * b -: 8] =
            lane_data[k][8 * (j * OCTETS_PER_SAMPLE + b) +: 8];
        end
      end
    end
  end

  // **********************************************************************
  // Output registers
  // **********************************************************************

  always_ff @(posedge device_clk) begin
    if (reset) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= lane_valid;
    end
  end

  always_ff @(posedge device_clk) begin
    if (lane_valid) begin
      rx_samples <= unpacked;
    end
  end

endmodule

// File: hw/lane_descrambler.sv
// **********************************************************************
// Descrambler for one loopback lane, the inverse of lane_scrambler. The
// history is fed from the received bits, so with both states at zero
// the data comes back exactly. scramble_enable must match the far end
// and only change while the link is idle.
// **********************************************************************

`timescale 1ns/10ps

module lane_descrambler (
  input  logic                    device_clk,
  input  logic                    reset,
  input  logic                    scramble_enable,
  input  jesd_tx_pkg::lane_word_t data_in,
  input  logic                    data_valid,
  output jesd_tx_pkg::lane_word_t data_out,
  output logic                    out_valid
);

  import jesd_tx_pkg::*;

  // state[n] holds the received bit n+1 places back
  logic [SCRAMBLE_STATE_BITS-1:0] state;
  logic [SCRAMBLE_STATE_BITS-1:0] next_state;
  lane_word_t                     descrambled;

  // **********************************************************************
  // Unrolled serial steps in transmit order
  // **********************************************************************

  always_comb begin
    int bit_pos;
    bit_pos = 0;
    descrambled = data_in;
    next_state = state;
    for (int n = 0; n < LANE_BITS; n++) begin
      bit_pos = 8 * (n / 8) + 7 - (n % 8);
      descrambled[bit_pos] = data_in[bit_pos] ^ next_state[SCRAMBLE_STATE_BITS-2]
                             ^ next_state[SCRAMBLE_STATE_BITS-1];
      // Shift in the line bit, not the recovered one
      next_state = {next_state[SCRAMBLE_STATE_BITS-2:0], data_in[bit_pos]};
    end
  end

  always_ff @(posedge device_clk) begin
    if (reset) begin
      state <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= data_valid;
      if (data_valid && scramble_enable) begin
        state <= next_state;
      end
    end
  end

  always_ff @(posedge device_clk) begin
    if (data_valid) begin
      data_out <= scramble_enable ? descrambled : data_in;
    end
  end

endmodule

// File: hw/lane_scrambler.sv
// **********************************************************************
// Self-synchronous 1 + x^14 + x^15 scrambler for one lane. The serial
// order is octet 0 first, MSB first within each octet. The state only
// moves on valid beats while scramble_enable is high; otherwise words
// pass unchanged. The state starts at zero after reset.
// **********************************************************************

`timescale 1ns/10ps

module lane_scrambler (
  input  logic                    device_clk,
  input  logic                    reset,
  input  logic                    scramble_enable,
  input  jesd_tx_pkg::lane_word_t data_in,
  input  logic                    data_valid,
  output jesd_tx_pkg::lane_word_t data_out,
  output logic                    out_valid
);

  import jesd_tx_pkg::*;

  // state[n] holds the output bit n+1 places back
  logic [SCRAMBLE_STATE_BITS-1:0] state;
  logic [SCRAMBLE_STATE_BITS-1:0] next_state;
  lane_word_t                     scrambled;

  // **********************************************************************
  // Unrolled serial steps, one per lane bit
  // **********************************************************************

  always_comb begin
    int bit_pos;
    bit_pos = 0;
    scrambled = data_in;
    next_state = state;
    for (int n = 0; n < LANE_BITS; n++) begin
      // Serial bit n sits in octet n/8, counted from the MSB
      bit_pos = 8 * (n / 8) + 7 - (n % 8);
      scrambled[bit_pos] = data_in[bit_pos] ^ next_state[SCRAMBLE_STATE_BITS-2]
                           ^ next_state[SCRAMBLE_STATE_BITS-1];
      // The history is fed from the scrambled bit
      next_state = {next_state[SCRAMBLE_STATE_BITS-2:0], scrambled[bit_pos]};
    end
  end

  always_ff @(posedge device_clk) begin
    if (reset) begin
      state <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= data_valid;
      if (data_valid && scramble_enable) begin
        state <= next_state;
      end
    end
  end

  always_ff @(posedge device_clk) begin
    if (data_valid) begin
      data_out <= scramble_enable ? scrambled : data_in;
    end
  end

endmodule

// File: hw/jesd_tx_framer.sv
// **********************************************************************
// Transport-layer framer. Lane k carries converter k and each sample is
// sent MSB octet first, in sample order. One cycle of latency, no
// back-pressure. Assumes NUM_LANES equals NUM_CONVERTERS.
// **********************************************************************

`timescale 1ns/10ps

module jesd_tx_framer (
  input  logic                         device_clk,
  input  logic                         reset,
  input  jesd_tx_pkg::converter_beat_t frame_samples,
  input  logic                         frame_valid,
  output jesd_tx_pkg::lane_beat_t      lane_data,
  output logic                         lane_valid
);

  import jesd_tx_pkg::*;

  // Lane words before the output register
  lane_beat_t framed;

  // **********************************************************************
  // Octet mapping
  // **********************************************************************

  always_comb begin
    framed = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        for (int b = 0; b < OCTETS_PER_SAMPLE; b++) begin
          // Octet b of sample j lands at lane octet j*OCTETS_PER_SAMPLE + b
          // Octet 0 of a sample is its upper byte
          framed[k][8 * (j * OCTETS_PER_SAMPLE + b) +: 8] =
            frame_samples.samples[k][j][SAMPLE_BITS - 1 - 8 * b -: 8];
        end
      end
    end
  end

  // **********************************************************************
  // Output registers
  // **********************************************************************

  always_ff @(posedge device_clk) begin
    if (reset) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= frame_valid;
    end
  end

  // Lane payload only loads on valid beats
  always_ff @(posedge device_clk) begin
    if (frame_valid) begin
      lane_data <= framed;
    end
  end

endmodule

// File: hw/dac_pattern_gen.sv
// **********************************************************************
// Per-converter test pattern for the DAC path. The first 256 samples of
// every 512 hold the converter index in each nibble, the next 256 hold
// the index in the top nibble and a running count in the low byte.
// The counter holds while tx_enable is low and is never cleared.
// **********************************************************************

`timescale 1ns/10ps

module dac_pattern_gen (
  input  logic                        device_clk,
  input  logic                        reset,
  input  logic                        tx_enable,
  output jesd_tx_pkg::converter_beat_t tx_samples,
  output logic                        tx_valid
);

  import jesd_tx_pkg::*;

  // Index of the first sample of the current beat
  logic [PATTERN_COUNT_BITS-1:0] sample_count;

  // Pattern for the beat that starts at sample_count
  converter_beat_t pattern;

  // **********************************************************************
  // Pattern decode
  // **********************************************************************

  always_comb begin
    pattern = '0;
    for (int i = 0; i < NUM_CONVERTERS; i++) begin
      for (int j = 0; j < SAMPLES_PER_BEAT; j++) begin
        if (sample_count[8]) begin
          // Ramp phase, bits 11:8 stay zero
          pattern.samples[i][j][SAMPLE_BITS-1 -: 4] = 4'(i);
          pattern.samples[i][j][7:0] = 8'(sample_count[7:0] + 8'(j));
        end else begin
          // Index phase, the converter number fills every nibble
          pattern.samples[i][j] = {(SAMPLE_BITS / 4){4'(i)}};
        end
      end
    end
  end

  // **********************************************************************
  // Counter and output registers
  // **********************************************************************

  always_ff @(posedge device_clk) begin
    if (reset) begin
      sample_count <= '0;
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= tx_enable;
      // Advance only on enabled beats so a gap skips no samples
      if (tx_enable) begin
        sample_count <= sample_count + PATTERN_COUNT_BITS'(SAMPLES_PER_BEAT);
      end
    end
  end

  // The sample payload carries no reset
  always_ff @(posedge device_clk) begin
    if (tx_enable) begin
      tx_samples <= pattern;
    end
  end

endmodule

// File: hw/jesd_tx_pkg.sv
// **********************************************************************
// Link constants and beat types for the JESD204B transmit data path.
// Only the transport layer is modelled. Lane k carries converter k, so
// NUM_LANES must equal NUM_CONVERTERS. Samples are 16 bits (NP of 12
// is not supported) and every lane moves four octets per cycle.
// **********************************************************************

package jesd_tx_pkg;

  // Converters per link (M)
  localparam int NUM_CONVERTERS = 2;

  // Lanes per link (L), one converter per lane
  localparam int NUM_LANES = 2;

  // Sample width (NP), already padded to the DMA width
  localparam int SAMPLE_BITS = 16;

  // Four octets leave each lane on every device_clk cycle
  localparam int LANE_BITS = 32;

  // Samples of one converter carried per cycle
  localparam int SAMPLES_PER_BEAT =
    (NUM_LANES * LANE_BITS) / (NUM_CONVERTERS * SAMPLE_BITS);

  // Octets that make up one sample on the lane
  localparam int OCTETS_PER_SAMPLE = SAMPLE_BITS / 8;

  // Pattern counter width. Bit 8 selects the phase and the low byte feeds
  // the ramp, so the counter wraps every 512 samples
  localparam int PATTERN_COUNT_BITS = 9;

  // Scrambler history for the 1 + x^14 + x^15 polynomial
  localparam int SCRAMBLE_STATE_BITS = 15;

  // One converter sample
  typedef logic [SAMPLE_BITS-1:0] sample_t;

  // One lane word, octet 0 in bits 7:0 goes out first
  typedef logic [LANE_BITS-1:0] lane_word_t;

  // All samples of one cycle, indexed by converter and then by sample
  typedef struct packed {
    sample_t [NUM_CONVERTERS-1:0][SAMPLES_PER_BEAT-1:0] samples;
  } converter_beat_t;

  // One word per lane
  typedef lane_word_t [NUM_LANES-1:0] lane_beat_t;

endpackage
